// File: sources.f
+incdir+logic
logic/ir_line_pkg.sv
logic/remote_cmd_pkg.sv
logic/ir_pulse_meter.sv
logic/nec_frame_decoder.sv
logic/key_pulse_gen.sv
logic/ir_remote_top.sv
test/ir_remote_props.sv
test/tb_ir_remote.sv

// File: Bender.yml
package:
  name: ir_remote

export_include_dirs:
  - logic

sources:
  # design, packages first
  - files:
      - logic/ir_line_pkg.sv
      - logic/remote_cmd_pkg.sv
      - logic/ir_pulse_meter.sv
      - logic/nec_frame_decoder.sv
      - logic/key_pulse_gen.sv
      - logic/ir_remote_top.sv

  # testbench and bound assertions
  - target: test
    files:
      - test/ir_remote_props.sv
      - test/tb_ir_remote.sv

// File: test/tb_ir_remote.sv
// IR remote testbench with clock, reset, random IR waveforms, frame model, checks and timeout
`timescale 1ns/1ns

`include "ir_remote_cfg.svh"

module tb_ir_remote
    import remote_cmd_pkg::*;
;

    localparam int unit_clks   = 4 * `IR_TICK_DIV;  // one waveform unit of 4 ticks
    localparam int gap_units   = 40;
    localparam int n_directed  = 16;
    localparam int n_random    = 40;
    localparam int frame_units = 200;               // longest frame plus gap
    localparam int timeout_cycles = (n_directed + n_random) * frame_units * unit_clks + 2000;

    localparam int lead_full  = 0;
    localparam int lead_short = 1;
    localparam int lead_rpt   = 2;

    logic       clk;
    logic       rst_n;
    logic       ir_rxb;
    key_vec_t   keys;
    logic [7:0] cmd_code;

    integer     seed = 11220;
    int         error_count = 0;
    int         cycle_cnt = 0;
    logic [7:0] exp_cmd = 8'h00;    // model of the last valid command

    // monitor state
    key_vec_t   keys_q = '0;
    key_vec_t   last_key = '0;
    int         high_len = 0;
    int         pulse_total = 0;

    ir_remote_top u_ir_remote_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ir_rxb   (ir_rxb),
        .o_keys     (keys),
        .o_cmd_code (cmd_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ========================================================================
    // checks and model helpers
    // ========================================================================
    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            $display("Errors found");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic key_vec_t key_of(input logic [7:0] cmd);
        key_vec_t k;
        k = '0;
        case (cmd)
            8'h40:   k.menu  = 1'b1;
            8'h10:   k.left  = 1'b1;
            8'hA0:   k.up    = 1'b1;
            8'h00:   k.power = 1'b1;
            default: k = '0;
        endcase
        return k;
    endfunction

    function automatic nec_frame_t make_frame(input logic [7:0] cmd);
        nec_frame_t f;
        f.addr   = $random(seed);
        f.addr_n = ~f.addr;
        f.cmd    = cmd;
        f.cmd_n  = ~cmd;
        return f;
    endfunction

    function automatic logic [7:0] random_unknown_cmd();
        logic [7:0] c;
        c = $random(seed);
        while (key_of(c) != '0) begin
            c = $random(seed);
        end
        return c;
    endfunction

    // ========================================================================
    // IR waveform generator
    // ========================================================================
    task automatic drive_level(input logic mark, input int units);
        ir_rxb <= ~mark;                    // receiver output is active low
        repeat (units * unit_clks) @(posedge clk);
    endtask

    task automatic send_and_check(input nec_frame_t f, input int lead_kind);
        int       pulses_before;
        key_vec_t exp_key;
        exp_key       = '0;
        pulses_before = pulse_total;
        if (lead_kind == lead_full && f.cmd_n == ~f.cmd) begin
            exp_cmd = f.cmd;
            exp_key = key_of(f.cmd);
        end
        if (lead_kind == lead_rpt) begin
            drive_level(1'b1, 16);
            drive_level(1'b0, 4);
        end else begin
            drive_level(1'b1, (lead_kind == lead_short) ? 8 : 16);
            drive_level(1'b0, 8);
            for (int i = 0; i < 32; i++) begin  // bit 0 goes out first
                drive_level(1'b1, 1);
                drive_level(1'b0, f[i] ? 3 : 1);
            end
        end
        drive_level(1'b1, 1);       // stop mark
        drive_level(1'b0, gap_units);
        check_value("key pulse count", pulse_total - pulses_before, (exp_key != '0) ? 1 : 0);
        if (exp_key != '0) begin
            check_value("o_keys", last_key, exp_key);
        end
        check_value("o_cmd_code", cmd_code, exp_cmd);
    endtask

    task automatic send_corrupt(input logic [7:0] cmd);
        nec_frame_t f;
        logic [2:0] pos;
        f   = make_frame(cmd);
        pos = $random(seed);
        f.cmd_n[pos] = ~f.cmd_n[pos];
        send_and_check(f, lead_full);
    endtask

    // ========================================================================
    // key pulse monitor
    // ========================================================================
    always @(posedge clk) begin
        keys_q <= keys;
        if (keys != '0) begin
            if (keys_q == '0) begin     // rising edge of a pulse
                pulse_total <= pulse_total + 1;
                last_key    <= keys;
                high_len    <= 1;
            end else begin
                high_len <= high_len + 1;
            end
        end else if (keys_q != '0) begin
            check_value("o_keys pulse length", high_len, `KEY_PULSE_LEN);
        end
    end

    always @(posedge clk) begin
        if (u_ir_remote_top.u_key_pulse_gen.u_props.fail_cnt != 0) begin
            $display("Assertion failure in the key pulse generator");
            $display("Errors found");
            $fatal(1, "assertion failed");
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("Timeout: stimulus did not finish within %0d cycles", timeout_cycles);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin : stim
        int         kind;
        logic [31:0] r;
        key_cmd_e   known [4];
        known  = '{CMD_MENU, CMD_LEFT, CMD_UP, CMD_POWER};
        rst_n  = 1'b0;
        ir_rxb = 1'b1;              // idle line without carrier
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge clk);
        check_value("o_keys", keys, 0);
        check_value("o_cmd_code", cmd_code, 0);

        for (int i = 0; i < 4; i++) begin
            send_and_check(make_frame(known[i]), lead_full);
        end
        repeat (4) send_and_check(make_frame(random_unknown_cmd()), lead_full);
        repeat (4) send_corrupt($random(seed));
        // repeat code and short leader each followed by a good frame
        send_and_check(make_frame(CMD_UP), lead_rpt);
        send_and_check(make_frame(CMD_MENU), lead_full);
        send_and_check(make_frame(CMD_POWER), lead_short);
        send_and_check(make_frame(CMD_LEFT), lead_full);

        for (int n = 0; n < n_random; n++) begin
            r    = $random(seed);
            kind = r[7:0] % 5;
            case (kind)
                0:       send_and_check(make_frame(known[r[9:8]]), lead_full);
                1:       send_and_check(make_frame(random_unknown_cmd()), lead_full);
                2:       send_corrupt(r[23:16]);
                3:       send_and_check(make_frame(r[23:16]), lead_rpt);
                default: send_and_check(make_frame(r[23:16]), lead_short);
            endcase
        end

        if (error_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: test/ir_remote_props.sv
// handshake and key pulse assertions bound into the key pulse generator
`timescale 1ns/1ns

`include "ir_remote_cfg.svh"

module ir_remote_props
    import remote_cmd_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     i_frame_req,
    input logic     i_frame_ack,
    input key_vec_t i_keys
);

    logic        keys_on;
    int unsigned fail_cnt = 0;  // failed assertions so far

    assign keys_on = (i_keys != '0);

    // req held until the key stage answers
    req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        i_frame_req && !i_frame_ack |=> i_frame_req)
        else begin
            $error("frame_req dropped before frame_ack");
            fail_cnt++;
        end

    // ack held while req is still up
    ack_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
        i_frame_ack && i_frame_req |=> i_frame_ack)
        else begin
            $error("frame_ack dropped while frame_req still high");
            fail_cnt++;
        end

    // new transfer only once the old one is closed
    req_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_frame_req) |-> !i_frame_ack)
        else begin
            $error("frame_req raised while frame_ack high");
            fail_cnt++;
        end

    keys_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(i_keys))
        else begin
            $error("more than one key active");
            fail_cnt++;
        end

    pulse_len_a: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(keys_on) |-> keys_on [*`KEY_PULSE_LEN] ##1 !keys_on)
        else begin
            $error("key pulse width wrong");
            fail_cnt++;
        end

endmodule

bind key_pulse_gen ir_remote_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_frame_req (i_frame_req),
    .i_frame_ack (o_frame_ack),
    .i_keys      (o_keys)
);

// File: logic/ir_remote_top.sv
// IR remote receiver top: pulse meter, NEC frame decoder, key pulse generator
`timescale 1ns/1ns

module ir_remote_top
    import ir_line_pkg::*;
    import remote_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_ir_rxb,       // active low receiver output
    output key_vec_t    o_keys,
    output logic [7:0]  o_cmd_code
);

    pulse_meas_t meas;
    logic        meas_vld;
    nec_frame_t  frame;
    logic        frame_req;
    logic        frame_ack;

    // line side, widths of marks and spaces
    ir_pulse_meter u_pulse_meter (
        .clk        (clk),
        .rst_n      (rst_n),
        .i_ir_rxb   (i_ir_rxb),
        .o_meas     (meas),
        .o_meas_vld (meas_vld)
    );

    nec_frame_decoder u_frame_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_meas      (meas),
        .i_meas_vld  (meas_vld),
        .o_frame     (frame),
        .o_frame_req (frame_req),
        .i_frame_ack (frame_ack)
    );

    // key side, four-phase req/ack with the decoder
    key_pulse_gen u_key_pulse_gen (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_frame     (frame),
        .i_frame_req (frame_req),
        .o_frame_ack (frame_ack),
        .o_keys      (o_keys),
        .o_cmd_code  (o_cmd_code)
    );

endmodule

// File: logic/key_pulse_gen.sv
// key pulse generator: ack side of the frame handshake, command register, key map, pulse timer
`timescale 1ns/1ns

`include "ir_remote_cfg.svh"

module key_pulse_gen
    import remote_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  nec_frame_t  i_frame,
    input  logic        i_frame_req,
    output logic        o_frame_ack,
    output key_vec_t    o_keys,
    output logic [7:0]  o_cmd_code      // last accepted command
);

    localparam int unsigned cnt_w = $clog2(`KEY_PULSE_LEN + 1);

    logic [cnt_w-1:0] pulse_cnt;    // cycles left of the running pulse
    logic             pulse_busy;
    logic             capture;
    key_vec_t         key_map;

    // =====================================================================
    // command to key mapping
    // =====================================================================
    always_comb begin
        key_map = '0;
        case (i_frame.cmd)
            CMD_MENU:  key_map.menu  = 1'b1;
            CMD_LEFT:  key_map.left  = 1'b1;
            CMD_UP:    key_map.up    = 1'b1;
            CMD_POWER: key_map.power = 1'b1;
            default:   key_map = '0;  // unknown code, no key
        endcase
    end

    assign pulse_busy = (pulse_cnt != '0);
    // a running pulse holds back the ack
    assign capture    = i_frame_req && !o_frame_ack && !pulse_busy;

    // =====================================================================
    // handshake, command register and pulse timer
    // =====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_frame_ack <= 1'b0;
            o_cmd_code  <= '0;
            o_keys      <= '0;
            pulse_cnt   <= '0;
        end else begin
            if (capture) begin
                o_frame_ack <= 1'b1;
                o_cmd_code  <= i_frame.cmd;
                o_keys      <= key_map;
                pulse_cnt   <= (key_map != '0) ? cnt_w'(`KEY_PULSE_LEN) : '0;
            end else begin
                if (o_frame_ack && !i_frame_req) begin
                    o_frame_ack <= 1'b0;    // req gone, close the transfer
                end
                if (pulse_busy) begin
                    pulse_cnt <= pulse_cnt - 1'b1;
                    if (pulse_cnt == 1) begin
                        o_keys <= '0;
                    end
                end
            end
        end
    end

endmodule

// File: logic/nec_frame_decoder.sv
// NEC frame decoder: leader check, 32-bit assembly, command complement check, req sender
`timescale 1ns/1ns

`include "ir_remote_cfg.svh"

module nec_frame_decoder
    import ir_line_pkg::*;
    import remote_cmd_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  pulse_meas_t i_meas,
    input  logic        i_meas_vld,
    output nec_frame_t  o_frame,
    output logic        o_frame_req,
    input  logic        i_frame_ack
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LEAD_SPACE,
        ST_BITS,
        ST_SEND
    } dec_state_e;

    dec_state_e state;
    logic [5:0] bit_cnt;        // bits taken so far
    nec_frame_t frame_nxt;      // frame with the current bit merged in
    logic       is_mark;
    logic       is_space;
    logic       space_bit;
    logic       last_bit;
    logic       cmd_ok;

    // =====================================================================
    // measurement classification
    // =====================================================================
    assign is_mark   = (i_meas.level == LVL_MARK);
    assign is_space  = (i_meas.level == LVL_SPACE);
    assign space_bit = (i_meas.len >= `IR_ONE_SPACE_MIN);   // long space is a 1
    assign last_bit  = (bit_cnt == 6'd31);

    always_comb begin
        frame_nxt = o_frame;
        frame_nxt[bit_cnt[4:0]] = space_bit;
    end

    // command byte must arrive with its complement
    assign cmd_ok = (frame_nxt.cmd_n == ~frame_nxt.cmd);

    // =====================================================================
    // frame FSM and req side of the handshake
    // =====================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= ST_IDLE;
            bit_cnt     <= '0;
            o_frame_req <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_meas_vld && is_mark && i_meas.len >= `IR_LEAD_MARK_MIN) begin
                        state <= ST_LEAD_SPACE;
                    end
                end
                ST_LEAD_SPACE: begin
                    if (i_meas_vld) begin
                        bit_cnt <= '0;
                        // repeat codes have a short space and stop here
                        if (is_space && i_meas.len >= `IR_LEAD_SPACE_MIN) begin
                            state <= ST_BITS;
                        end else begin
                            state <= ST_IDLE;
                        end
                    end
                end
                ST_BITS: begin
                    if (i_meas_vld) begin
                        if (is_mark) begin
                            if (i_meas.len > `IR_BIT_MARK_MAX) begin
                                state <= ST_IDLE;   // not a bit mark
                            end
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (last_bit) begin
                                // ack still high means the last transfer is not closed
                                if (cmd_ok && !i_frame_ack) begin
                                    state       <= ST_SEND;
                                    o_frame_req <= 1'b1;
                                end else begin
                                    state <= ST_IDLE;
                                end
                            end
                        end
                    end
                end
                ST_SEND: begin
                    if (i_frame_ack) begin
                        o_frame_req <= 1'b0;
                        state       <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // frame bits, held while req is up
    always_ff @(posedge clk) begin
        if (state == ST_BITS && i_meas_vld && is_space) begin
            o_frame <= frame_nxt;
        end
    end

endmodule

// File: logic/ir_pulse_meter.sv
// IR pulse meter: sample tick, line synchronizer, mark and space run-length counter
`timescale 1ns/1ns

`include "ir_remote_cfg.svh"

module ir_pulse_meter
    import ir_line_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        i_ir_rxb,       // raw line, low while carrier present
    output pulse_meas_t o_meas,
    output logic        o_meas_vld
);

    logic [$clog2(`IR_TICK_DIV)-1:0] tick_cnt;
    logic                            tick;
    logic [1:0]                      sync_q;    // [1] is the settled level
    ir_level_e                       run_lvl;   // level being measured
    logic [`IR_MEAS_W-1:0]           run_len;
    logic                            lvl_change;

    // =====================================================================
    // sample tick
    // =====================================================================
    assign tick = (tick_cnt == `IR_TICK_DIV - 1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // two stage synchronizer, clocked by the tick, line inverted on entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= '0;               // idle line reads as space
        end else if (tick) begin
            sync_q <= {sync_q[0], ~i_ir_rxb};
        end
    end

    // =====================================================================
    // run-length counter
    // =====================================================================
    assign lvl_change = (ir_level_e'(sync_q[1]) != run_lvl);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_lvl    <= LVL_SPACE;
            run_len    <= '0;
            o_meas_vld <= 1'b0;
        end else begin
            o_meas_vld <= 1'b0;
            if (tick) begin
                if (lvl_change) begin
                    run_lvl    <= ir_level_e'(sync_q[1]);
                    run_len    <= {{(`IR_MEAS_W-1){1'b0}}, 1'b1};  // new run, first tick
                    o_meas_vld <= 1'b1;
                end else if (run_len < `IR_MEAS_MAX) begin
                    run_len <= run_len + 1'b1;
                end
            end
        end
    end

    // ended level and its length, valid with the strobe
    always_ff @(posedge clk) begin
        if (tick && lvl_change) begin
            o_meas.level <= run_lvl;
            o_meas.len   <= run_len;
        end
    end

endmodule

// File: logic/remote_cmd_pkg.sv
// remote command types: NEC frame struct, command opcode enum, key vector
package remote_cmd_pkg;

    // =====================================================================
    // NEC frame, first received bit lands in bit 0
    // =====================================================================
    typedef struct packed {
        logic [7:0] cmd_n;  // inverted command, sent last
        logic [7:0] cmd;
        logic [7:0] addr_n;
        logic [7:0] addr;   // sent first
    } nec_frame_t;

    // =====================================================================
    // known command codes of the handset
    // =====================================================================
    typedef enum logic [7:0] {
        CMD_POWER = 8'h00,
        CMD_LEFT  = 8'h10,
        CMD_MENU  = 8'h40,
        CMD_UP    = 8'hA0
    } key_cmd_e;

    // one bit per key, at most one set at a time
    typedef struct packed {
        logic menu;
        logic left;
        logic up;
        logic power;
    } key_vec_t;

endpackage

// File: logic/ir_line_pkg.sv
// IR line types: line level enum and pulse measurement struct
`include "ir_remote_cfg.svh"

package ir_line_pkg;

    // level of the inverted receiver line
    typedef enum logic {
        LVL_SPACE = 1'b0,   // no carrier
        LVL_MARK  = 1'b1    // carrier burst
    } ir_level_e;

    // one finished run of a steady level
    typedef struct packed {
        ir_level_e              level;  // level that just ended
        logic [`IR_MEAS_W-1:0]  len;    // ticks, saturating
    } pulse_meas_t;

endpackage

// File: logic/ir_remote_cfg.svh
// sample tick divider, pulse width thresholds, saturation limit, key pulse length
`ifndef IR_REMOTE_CFG_SVH
`define IR_REMOTE_CFG_SVH

// =========================================================================
// line sampling
// =========================================================================

// clk cycles per sample tick
`define IR_TICK_DIV         4

// measured length width and its saturation value, in ticks
`define IR_MEAS_W           8
`define IR_MEAS_MAX         255

// =========================================================================
// frame timing, all in sample ticks
// =========================================================================

`define IR_LEAD_MARK_MIN    48  // leader burst, shorter is noise
`define IR_LEAD_SPACE_MIN   24  // repeat codes fall below this
`define IR_BIT_MARK_MAX     8   // longer mark inside a frame aborts it
`define IR_ONE_SPACE_MIN    8   // space from here up decodes as 1

// =========================================================================
// key output
// =========================================================================

// width of one key pulse, clk cycles
`define KEY_PULSE_LEN       8

`endif
